// File: hdl/dcache_pkg.sv
// cache core types; 64-bit words, one valid bit per way, NumBanks words per line
package dcache_pkg;

  ////////////////////////////////////////
  // geometry
  ////////////////////////////////////////

  localparam int unsigned TagWidth     = 16;
  localparam int unsigned IdxWidth     = 6;
  localparam int unsigned NumSets      = 1 << IdxWidth;
  localparam int unsigned NumWays      = 4;
  localparam int unsigned NumBanks     = 2;
  // 16 bytes per line, bank number sits above the 8-byte word offset
  localparam int unsigned OffWidth     = 4;
  localparam int unsigned BankSelWidth = 1;

  ////////////////////////////////////////
  // field types
  ////////////////////////////////////////

  typedef logic [TagWidth-1:0] tag_t;
  typedef logic [IdxWidth-1:0] idx_t;
  typedef logic [OffWidth-1:0] off_t;
  typedef logic [NumWays-1:0]  way_vec_t;
  typedef logic [63:0]         word_t;
  typedef word_t [NumBanks-1:0] line_t;

  ////////////////////////////////////////
  // port and array structs
  ////////////////////////////////////////

  typedef struct packed {
    idx_t idx;
    off_t off;
  } rd_port_t;

  typedef struct packed {
    logic     vld;
    way_vec_t way_en;    // ways to overwrite
    way_vec_t vld_bits;  // new valid bit per way
    tag_t     tag;
    idx_t     idx;
    line_t    line;
  } line_wr_t;

  typedef struct packed {
    way_vec_t                tag_en;
    logic                    tag_we;
    idx_t                    idx;
    logic [NumBanks-1:0]     bank_en;
    logic [NumBanks-1:0]     bank_we;
    logic [BankSelWidth-1:0] bank_sel;  // bank of the read word
  } array_req_t;

  typedef struct packed {
    tag_t [NumWays-1:0]  tag;
    way_vec_t            vld;
    word_t [NumWays-1:0] data;
  } array_rsp_t;

endpackage

// File: hdl/dcache_sram.sv
// behavioral single-port RAM; contents undefined after power-up, read data held when idle
`timescale 1ns/100ps

module dcache_sram #(
  parameter int unsigned DataWidth = 64,
  parameter int unsigned Depth     = 64
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  logic [DataWidth-1:0]     wdata_i,
  output logic [DataWidth-1:0]     rdata_o
);

  logic [DataWidth-1:0] mem_q [Depth];

  // write wins, a read returns the stored word one cycle later
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// File: hdl/dcache_port_arbiter.sv
// NumPorts must be at least 2; a line write takes the arrays and blocks every read grant
`timescale 1ns/100ps

module dcache_port_arbiter import dcache_pkg::*; #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [NumPorts-1:0]         rd_req_i,
  input  logic [NumPorts-1:0]         rd_prio_i,
  input  rd_port_t [NumPorts-1:0]     rd_addr_i,
  input  line_wr_t                    line_wr_i,
  output logic [NumPorts-1:0]         rd_ack_o,
  output array_req_t                  array_req_o,
  output logic                        lookup_vld_q_o,
  output logic [$clog2(NumPorts)-1:0] port_sel_q_o
);

  logic [NumPorts-1:0]         req_prio;
  logic [NumPorts-1:0]         req_masked;
  logic [$clog2(NumPorts)-1:0] rr_ptr_q;
  logic [$clog2(NumPorts)-1:0] gnt_idx;
  logic                        gnt_vld;
  logic                        rd_acked;

  ////////////////////////////////////////
  // priority masking and round robin
  ////////////////////////////////////////

  // high priority requests hide the low priority ones
  assign req_prio   = rd_req_i & rd_prio_i;
  assign req_masked = (|req_prio) ? req_prio : rd_req_i;

  always_comb begin
    int unsigned cand;
    gnt_idx = '0;
    gnt_vld = 1'b0;
    // first requester at or after the pointer, wrapping
    for (int unsigned i = 0; i < NumPorts; i++) begin
      cand = int'(rr_ptr_q) + i;
      if (cand >= NumPorts) begin
        cand = cand - NumPorts;
      end
      if (!gnt_vld && req_masked[cand]) begin
        gnt_vld = 1'b1;
        gnt_idx = cand[$clog2(NumPorts)-1:0];
      end
    end
  end

  assign rd_acked = gnt_vld & ~line_wr_i.vld;

  always_comb begin
    rd_ack_o = '0;
    if (rd_acked) begin
      rd_ack_o[gnt_idx] = 1'b1;
    end
  end

  ////////////////////////////////////////
  // array command
  ////////////////////////////////////////

  always_comb begin
    array_req_o = '0;
    if (line_wr_i.vld) begin
      // full line fill of the chosen ways
      array_req_o.tag_en  = line_wr_i.way_en;
      array_req_o.tag_we  = 1'b1;
      array_req_o.idx     = line_wr_i.idx;
      array_req_o.bank_en = '1;
      array_req_o.bank_we = '1;
    end else if (rd_acked) begin
      array_req_o.tag_en   = '1;
      array_req_o.idx      = rd_addr_i[gnt_idx].idx;
      array_req_o.bank_sel = rd_addr_i[gnt_idx].off[OffWidth-1 -: BankSelWidth];
      array_req_o.bank_en[rd_addr_i[gnt_idx].off[OffWidth-1 -: BankSelWidth]] = 1'b1;
    end
  end

  ////////////////////////////////////////
  // state
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q       <= '0;
      lookup_vld_q_o <= 1'b0;
      port_sel_q_o   <= '0;
    end else begin
      lookup_vld_q_o <= rd_acked;
      if (rd_acked) begin
        port_sel_q_o <= gnt_idx;
        // pointer moves just past the winner
        if (int'(gnt_idx) == NumPorts - 1) begin
          rr_ptr_q <= '0;
        end else begin
          rr_ptr_q <= gnt_idx + 1'b1;
        end
      end
    end
  end

endmodule

// File: hdl/dcache_arrays.sv
// one-cycle read latency; each bank RAM is split in 64-bit way slices so a fill keeps other ways
`timescale 1ns/100ps

module dcache_arrays import dcache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  array_req_t array_req_i,
  input  line_wr_t   line_wr_i,
  output array_rsp_t array_rsp_o
);

  way_vec_t                        vld_q [NumSets];
  way_vec_t                        vld_rd_q;
  logic [BankSelWidth-1:0]         bank_sel_q;
  word_t [NumBanks-1:0][NumWays-1:0] bank_rdata;

  ////////////////////////////////////////
  // tag RAMs and valid flops
  ////////////////////////////////////////

  for (genvar w = 0; w < NumWays; w++) begin : gen_tag
    dcache_sram #(
      .DataWidth (TagWidth),
      .Depth     (NumSets)
    ) i_tag_sram (
      .clk_i   (clk_i),
      .req_i   (array_req_i.tag_en[w]),
      .we_i    (array_req_i.tag_we),
      .addr_i  (array_req_i.idx),
      .wdata_i (line_wr_i.tag),
      .rdata_o (array_rsp_o.tag[w])
    );
  end

  // valid bits live in flops so cold sets read as invalid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NumSets; s++) begin
        vld_q[s] <= '0;
      end
      vld_rd_q <= '0;
    end else if (array_req_i.tag_we) begin
      for (int w = 0; w < NumWays; w++) begin
        if (array_req_i.tag_en[w]) begin
          vld_q[array_req_i.idx][w] <= line_wr_i.vld_bits[w];
        end
      end
    end else if (|array_req_i.tag_en) begin
      vld_rd_q <= vld_q[array_req_i.idx];
    end
  end

  assign array_rsp_o.vld = vld_rd_q;

  ////////////////////////////////////////
  // data banks
  ////////////////////////////////////////

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    for (genvar w = 0; w < NumWays; w++) begin : gen_way
      dcache_sram #(
        .DataWidth (64),
        .Depth     (NumSets)
      ) i_data_sram (
        .clk_i   (clk_i),
        .req_i   (array_req_i.bank_en[b]),
        .we_i    (array_req_i.bank_we[b] & line_wr_i.way_en[w]),
        .addr_i  (array_req_i.idx),
        .wdata_i (line_wr_i.line[b]),
        .rdata_o (bank_rdata[b][w])
      );
    end
  end

  // remember which bank the read went to
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_sel_q <= '0;
    end else begin
      bank_sel_q <= array_req_i.bank_sel;
    end
  end

  for (genvar w = 0; w < NumWays; w++) begin : gen_rdata
    assign array_rsp_o.data[w] = bank_rdata[bank_sel_q][w];
  end

endmodule

// File: hdl/dcache_tag_compare.sv
// purely combinational; rd_tag_i of the granted port must be valid the cycle after the grant
`timescale 1ns/100ps

module dcache_tag_compare import dcache_pkg::*; #(
  parameter int unsigned NumPorts = 3
) (
  input  tag_t [NumPorts-1:0]         rd_tag_i,
  input  logic                        lookup_vld_q_i,
  input  logic [$clog2(NumPorts)-1:0] port_sel_q_i,
  input  array_rsp_t                  array_rsp_i,
  output way_vec_t                    rd_hit_oh_o,
  output way_vec_t                    rd_vld_bits_o,
  output word_t                       rd_data_o
);

  tag_t rd_tag;

  // tag of the port granted last cycle
  assign rd_tag = rd_tag_i[port_sel_q_i];

  ////////////////////////////////////////
  // hit generation
  ////////////////////////////////////////

  for (genvar w = 0; w < NumWays; w++) begin : gen_cmp
    assign rd_hit_oh_o[w] = lookup_vld_q_i & array_rsp_i.vld[w] &
                            (array_rsp_i.tag[w] == rd_tag);
  end

  assign rd_vld_bits_o = array_rsp_i.vld;

  ////////////////////////////////////////
  // word select
  ////////////////////////////////////////

  // walk down so the lowest hitting way wins, zero on a miss
  always_comb begin
    rd_data_o = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (rd_hit_oh_o[w]) begin
        rd_data_o = array_rsp_i.data[w];
      end
    end
  end

endmodule

// File: hdl/dcache_mem.sv
// unacked read requests must be held; results appear the cycle after rd_ack_o
`timescale 1ns/100ps

module dcache_mem import dcache_pkg::*; #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // read ports
  input  logic [NumPorts-1:0]     rd_req_i,
  input  logic [NumPorts-1:0]     rd_prio_i,
  input  rd_port_t [NumPorts-1:0] rd_addr_i,
  input  tag_t [NumPorts-1:0]     rd_tag_i,
  output logic [NumPorts-1:0]     rd_ack_o,
  output way_vec_t                rd_hit_oh_o,
  output way_vec_t                rd_vld_bits_o,
  output word_t                   rd_data_o,
  // line fill
  input  line_wr_t                line_wr_i
);

  array_req_t                  array_req;
  array_rsp_t                  array_rsp;
  logic                        lookup_vld_q;
  logic [$clog2(NumPorts)-1:0] port_sel_q;

  dcache_port_arbiter #(
    .NumPorts (NumPorts)
  ) i_arbiter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rd_req_i       (rd_req_i),
    .rd_prio_i      (rd_prio_i),
    .rd_addr_i      (rd_addr_i),
    .line_wr_i      (line_wr_i),
    .rd_ack_o       (rd_ack_o),
    .array_req_o    (array_req),
    .lookup_vld_q_o (lookup_vld_q),
    .port_sel_q_o   (port_sel_q)
  );

  dcache_arrays i_arrays (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .array_req_i (array_req),
    .line_wr_i   (line_wr_i),
    .array_rsp_o (array_rsp)
  );

  dcache_tag_compare #(
    .NumPorts (NumPorts)
  ) i_tag_compare (
    .rd_tag_i       (rd_tag_i),
    .lookup_vld_q_i (lookup_vld_q),
    .port_sel_q_i   (port_sel_q),
    .array_rsp_i    (array_rsp),
    .rd_hit_oh_o    (rd_hit_oh_o),
    .rd_vld_bits_o  (rd_vld_bits_o),
    .rd_data_o      (rd_data_o)
  );

endmodule

// File: dv/tb_clock_gen.sv
// free-running clock of 100 ns; active-low reset held for the first 3 rising edges
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // release on the third rising edge
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: dv/dcache_mem_tb.sv
// directed tests for 3 read ports; only sets touched by a line write are modeled
`timescale 1ns/100ps

module dcache_mem_tb import dcache_pkg::*;;

  localparam int unsigned NumPorts = 3;
  // all tests together take under 100 cycles
  localparam int unsigned MaxCycles = 400;

  logic                    clk;
  logic                    rst_n;
  logic [NumPorts-1:0]     rd_req;
  logic [NumPorts-1:0]     rd_prio;
  rd_port_t [NumPorts-1:0] rd_addr;
  tag_t [NumPorts-1:0]     rd_tag;
  logic [NumPorts-1:0]     rd_ack;
  way_vec_t                rd_hit_oh;
  way_vec_t                rd_vld_bits;
  word_t                   rd_data;
  line_wr_t                line_wr;

  // model of what the line writes put into the arrays
  tag_t        tag_m  [NumSets][NumWays];
  way_vec_t    vld_m  [NumSets];
  line_t       line_m [NumSets][NumWays];
  integer      seed;
  int unsigned cycles;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dcache_mem #(
    .NumPorts (NumPorts)
  ) dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .rd_req_i      (rd_req),
    .rd_prio_i     (rd_prio),
    .rd_addr_i     (rd_addr),
    .rd_tag_i      (rd_tag),
    .rd_ack_o      (rd_ack),
    .rd_hit_oh_o   (rd_hit_oh),
    .rd_vld_bits_o (rd_vld_bits),
    .rd_data_o     (rd_data),
    .line_wr_i     (line_wr)
  );

  ////////////////////////////////////////
  // error handling and compares
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_way_vec(input string name, input way_vec_t got, input way_vec_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_ack(input logic [NumPorts-1:0] got, input logic [NumPorts-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH rd_ack_o got %h expected %h", got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      abort_run($sformatf("timeout, the tests did not finish within %0d cycles", MaxCycles));
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // call right after a rising edge; fills random data and updates the model
  task automatic drive_line_write(input idx_t idx, input way_vec_t way_en,
                                  input way_vec_t vld_bits, input tag_t tag);
    line_wr_t wr;
    wr.vld      = 1'b1;
    wr.way_en   = way_en;
    wr.vld_bits = vld_bits;
    wr.tag      = tag;
    wr.idx      = idx;
    for (int b = 0; b < NumBanks; b++) begin
      wr.line[b] = {$random(seed), $random(seed)};
    end
    line_wr <= wr;
    for (int w = 0; w < NumWays; w++) begin
      if (way_en[w]) begin
        tag_m[idx][w]  = tag;
        vld_m[idx][w]  = vld_bits[w];
        line_m[idx][w] = wr.line;
      end
    end
  endtask

  task automatic write_line(input idx_t idx, input way_vec_t way_en,
                            input way_vec_t vld_bits, input tag_t tag);
    @(posedge clk);
    drive_line_write(idx, way_en, vld_bits, tag);
    @(posedge clk);
    line_wr <= '0;
  endtask

  task automatic set_read(input int port, input idx_t idx, input int bank, input tag_t tag);
    rd_port_t addr;
    addr.idx = idx;
    // bank number sits in the upper offset bits
    addr.off = off_t'(bank << (OffWidth - BankSelWidth));
    rd_req[port]  <= 1'b1;
    rd_addr[port] <= addr;
    rd_tag[port]  <= tag;
  endtask

  // expected result from the model, lowest hitting way supplies the word
  task automatic check_lookup(input idx_t idx, input int bank, input tag_t tag);
    way_vec_t exp_hit;
    word_t    exp_data;
    exp_hit  = '0;
    exp_data = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (vld_m[idx][w] && tag_m[idx][w] == tag) begin
        if (exp_hit == '0) begin
          exp_data = line_m[idx][w][bank];
        end
        exp_hit[w] = 1'b1;
      end
    end
    check_way_vec("rd_hit_oh_o", rd_hit_oh, exp_hit);
    check_way_vec("rd_vld_bits_o", rd_vld_bits, vld_m[idx]);
    check_word("rd_data_o", rd_data, exp_data);
  endtask

  task automatic read_check(input int port, input idx_t idx, input int bank, input tag_t tag);
    logic [NumPorts-1:0] exp_ack;
    exp_ack       = '0;
    exp_ack[port] = 1'b1;
    @(posedge clk);
    set_read(port, idx, bank, tag);
    @(negedge clk);
    check_ack(rd_ack, exp_ack);
    // no grant in the previous cycle, so no hit even with stale array data
    check_way_vec("rd_hit_oh_o", rd_hit_oh, '0);
    @(posedge clk);
    rd_req <= '0;
    @(negedge clk);
    check_lookup(idx, bank, tag);
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic round_robin_test();
    logic [NumPorts-1:0] exp_ack;
    @(posedge clk);
    rd_req  <= '1;
    rd_prio <= '0;
    for (int i = 0; i < 6; i++) begin
      exp_ack = '0;
      exp_ack[i % NumPorts] = 1'b1;
      @(negedge clk);
      check_ack(rd_ack, exp_ack);
      @(posedge clk);
    end
    rd_req <= '0;
  endtask

  task automatic fill_hit_test();
    write_line(6'd5, 4'b0100, 4'b0100, 16'hbeef);
    for (int p = 0; p < NumPorts; p++) begin
      for (int b = 0; b < NumBanks; b++) begin
        read_check(p, 6'd5, b, 16'hbeef);
      end
    end
  endtask

  task automatic miss_invalidate_test();
    write_line(6'd5, 4'b0001, 4'b0001, 16'h1111);
    read_check(0, 6'd5, 0, 16'h2222);
    read_check(1, 6'd5, 1, 16'hbeef);
    // same tag, valid bit cleared
    write_line(6'd5, 4'b0100, 4'b0000, 16'hbeef);
    read_check(1, 6'd5, 1, 16'hbeef);
  endtask

  task automatic priority_test();
    @(posedge clk);
    rd_req  <= '1;
    rd_prio <= 3'b100;
    // the pointer wraps to port 0 after the first grant so only masking keeps port 2
    repeat (2) begin
      @(negedge clk);
      check_ack(rd_ack, 3'b100);
      @(posedge clk);
    end
    rd_req  <= '0;
    rd_prio <= '0;
  endtask

  task automatic write_blocks_read_test();
    @(posedge clk);
    set_read(1, 6'd9, 1, 16'h0a0a);
    drive_line_write(6'd9, 4'b0010, 4'b0010, 16'h0a0a);
    @(negedge clk);
    check_ack(rd_ack, '0);
    @(posedge clk);
    line_wr <= '0;
    @(negedge clk);
    check_ack(rd_ack, 3'b010);
    @(posedge clk);
    rd_req <= '0;
    @(negedge clk);
    check_lookup(6'd9, 1, 16'h0a0a);
  endtask

  initial begin
    seed    = 32'hf9a;
    cycles  = 0;
    rd_req  = '0;
    rd_prio = '0;
    rd_addr = '0;
    rd_tag  = '0;
    line_wr = '0;
    for (int s = 0; s < NumSets; s++) begin
      vld_m[s] = '0;
    end
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_ack(rd_ack, '0);
    check_way_vec("rd_hit_oh_o", rd_hit_oh, '0);
    round_robin_test();
    fill_hit_test();
    miss_invalidate_test();
    priority_test();
    write_blocks_read_test();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: project.f
hdl/dcache_pkg.sv
hdl/dcache_sram.sv
hdl/dcache_port_arbiter.sv
hdl/dcache_arrays.sv
hdl/dcache_tag_compare.sv
hdl/dcache_mem.sv
dv/tb_clock_gen.sv
dv/dcache_mem_tb.sv

// File: Makefile
TOP = dcache_mem_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
